// ==== rtl/demux_pkg.sv ====
/*
 * Shared definitions for the AXI4 read demultiplexer
 * Bus widths, ID and port-select types, AR lock states
 */
package demux_pkg;

  // Default configuration
  localparam int NUM_MST_PORTS = 4;
  localparam int LOOK_BITS     = 2;
  localparam int MAX_TRANS     = 4;

  // AXI field widths
  localparam int ID_WIDTH      = 4;
  localparam int ADDR_WIDTH    = 32;
  localparam int DATA_WIDTH    = 32;
  localparam int LEN_WIDTH     = 8;

  // Derived widths, counter must be able to hold MAX_TRANS itself
  localparam int CNT_WIDTH     = $clog2(MAX_TRANS + 1);
  localparam int SEL_WIDTH     = (NUM_MST_PORTS > 1) ? $clog2(NUM_MST_PORTS) : 1;

  typedef logic [ID_WIDTH-1:0]  id_t;
  typedef logic [LOOK_BITS-1:0] look_id_t;
  typedef logic [SEL_WIDTH-1:0] select_t;

  // AR valid lock
  typedef enum logic {
    AR_IDLE   = 1'b0,
    AR_LOCKED = 1'b1
  } ar_state_e;

endpackage

// ==== rtl/ar_route_ctrl.sv ====
/*
 * AR routing control
 * Checks ID ordering and table space, locks the valid once raised
 * and fans the request out to the selected manager port
 */
`timescale 1ns/1ns
module ar_route_ctrl #(
  parameter int NUM_MST_PORTS = demux_pkg::NUM_MST_PORTS
) (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  demux_pkg::id_t                   s_ar_id_i,
  input  logic [demux_pkg::ADDR_WIDTH-1:0] s_ar_addr_i,
  input  logic [demux_pkg::LEN_WIDTH-1:0]  s_ar_len_i,
  input  demux_pkg::select_t               s_ar_select_i,
  input  logic                             s_ar_valid_i,
  output logic                             s_ar_ready_o,
  output demux_pkg::id_t                   m_ar_id_o,
  output logic [demux_pkg::ADDR_WIDTH-1:0] m_ar_addr_o,
  output logic [demux_pkg::LEN_WIDTH-1:0]  m_ar_len_o,
  output logic [NUM_MST_PORTS-1:0]         m_ar_valid_o,
  input  logic [NUM_MST_PORTS-1:0]         m_ar_ready_i,
  output demux_pkg::look_id_t              lookup_id_o,
  input  logic                             occupied_i,
  input  demux_pkg::select_t               stored_select_i,
  input  logic                             full_i,
  output logic                             push_o
);
  import demux_pkg::*;

  ar_state_e state_q, state_d;
  logic      allowed;
  logic      ar_valid;
  logic      port_ready;

  // Same ID may only go to the port it already has reads on
  assign allowed    = s_ar_valid_i && !full_i &&
                      (!occupied_i || (stored_select_i == s_ar_select_i));
  assign ar_valid   = (state_q == AR_LOCKED) || allowed;
  assign port_ready = m_ar_ready_i[s_ar_select_i];

  assign s_ar_ready_o = ar_valid && port_ready;
  assign push_o       = ar_valid && port_ready;
  assign lookup_id_o  = look_id_t'(s_ar_id_i);

  // Payload is shared, only one valid bit is raised
  assign m_ar_id_o   = s_ar_id_i;
  assign m_ar_addr_o = s_ar_addr_i;
  assign m_ar_len_o  = s_ar_len_i;

  always_comb begin
    for (int i = 0; i < NUM_MST_PORTS; i++) begin
      m_ar_valid_o[i] = ar_valid && (s_ar_select_i == select_t'(i));
    end
  end

  // --------------------
  // Lock FSM
  always_comb begin
    state_d = state_q;
    case (state_q)
      AR_IDLE:   if (allowed && !port_ready) state_d = AR_LOCKED;
      AR_LOCKED: if (port_ready) state_d = AR_IDLE;
      default:   state_d = AR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= AR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------
  // Checks
  a_ar_valid_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (ar_valid && !port_ready) |=> (ar_valid && $stable(m_ar_valid_o)))
    else $error("m_ar_valid_o dropped or moved before acceptance");

  a_ar_select_range: assert property (@(posedge clk_i) disable iff (rst_i)
    s_ar_valid_i |-> (int'(s_ar_select_i) < NUM_MST_PORTS))
    else $error("s_ar_select_i out of range: %0d", s_ar_select_i);

endmodule

// ==== rtl/id_tracker.sv ====
/*
 * Outstanding-read table
 * One counter per low-order ID value plus the port its reads went to
 */
`timescale 1ns/1ns
module id_tracker #(
  parameter int LOOK_BITS = demux_pkg::LOOK_BITS,
  parameter int MAX_TRANS = demux_pkg::MAX_TRANS
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  demux_pkg::look_id_t lookup_id_i,
  output logic                occupied_o,
  output demux_pkg::select_t  stored_select_o,
  output logic                full_o,
  input  logic                push_i,
  input  demux_pkg::select_t  push_select_i,
  input  demux_pkg::look_id_t pop_id_i,
  input  logic                pop_i
);
  import demux_pkg::*;

  localparam int NUM_IDS = 2 ** LOOK_BITS;

  select_t              sel_q [NUM_IDS];
  logic [NUM_IDS-1:0]   occupied;
  logic [NUM_IDS-1:0]   cnt_full;

  assign occupied_o      = occupied[lookup_id_i];
  assign stored_select_o = sel_q[lookup_id_i];
  // Any full counter blocks new reads
  assign full_o          = |cnt_full;

  // Port of the latest push, valid while the entry is occupied
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      sel_q[lookup_id_i] <= push_select_i;
    end
  end

  // --------------------
  // In-flight counters
  for (genvar i = 0; i < NUM_IDS; i++) begin : gen_cnt
    logic                 push_en;
    logic                 pop_en;
    logic [CNT_WIDTH-1:0] cnt_q;

    assign push_en = push_i && (lookup_id_i == look_id_t'(i));
    assign pop_en  = pop_i && (pop_id_i == look_id_t'(i));

    // Push and pop on one entry cancel
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        cnt_q <= '0;
      end else if (push_en && !pop_en) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop_en && !push_en) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end

    assign occupied[i] = (cnt_q != '0);
    assign cnt_full[i] = (cnt_q == CNT_WIDTH'(MAX_TRANS));

    // A last R beat must belong to a read this table saw
    a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
      pop_en |-> (cnt_q != '0))
      else $error("ID entry %0d popped with zero outstanding reads", i);
  end

endmodule

// ==== rtl/r_arbiter.sv ====
/*
 * R channel merge
 * Round-robin over the manager ports with the grant held for a whole burst
 */
`timescale 1ns/1ns
module r_arbiter #(
  parameter int NUM_MST_PORTS = demux_pkg::NUM_MST_PORTS
) (
  input  logic                                                 clk_i,
  input  logic                                                 rst_i,
  input  demux_pkg::id_t [NUM_MST_PORTS-1:0]                   m_r_id_i,
  input  logic [NUM_MST_PORTS-1:0][demux_pkg::DATA_WIDTH-1:0]  m_r_data_i,
  input  logic [NUM_MST_PORTS-1:0][1:0]                        m_r_resp_i,
  input  logic [NUM_MST_PORTS-1:0]                             m_r_last_i,
  input  logic [NUM_MST_PORTS-1:0]                             m_r_valid_i,
  output logic [NUM_MST_PORTS-1:0]                             m_r_ready_o,
  output demux_pkg::id_t                                       s_r_id_o,
  output logic [demux_pkg::DATA_WIDTH-1:0]                     s_r_data_o,
  output logic [1:0]                                           s_r_resp_o,
  output logic                                                 s_r_last_o,
  output logic                                                 s_r_valid_o,
  input  logic                                                 s_r_ready_i,
  output demux_pkg::look_id_t                                  pop_id_o,
  output logic                                                 pop_o
);
  import demux_pkg::*;

  select_t rr_q;
  logic    lock_q;
  select_t lock_idx_q;
  select_t pick;
  logic    any_valid;
  select_t grant;
  logic    last_xfer;

  // First valid port at or after the pointer
  always_comb begin : p_pick
    int cand;
    any_valid = 1'b0;
    pick      = rr_q;
    for (int k = 0; k < NUM_MST_PORTS; k++) begin
      cand = (int'(rr_q) + k) % NUM_MST_PORTS;
      if (!any_valid && m_r_valid_i[cand]) begin
        any_valid = 1'b1;
        pick      = select_t'(cand);
      end
    end
  end

  assign grant       = lock_q ? lock_idx_q : pick;
  assign s_r_valid_o = lock_q ? m_r_valid_i[lock_idx_q] : any_valid;
  assign s_r_id_o    = m_r_id_i[grant];
  assign s_r_data_o  = m_r_data_i[grant];
  assign s_r_resp_o  = m_r_resp_i[grant];
  assign s_r_last_o  = m_r_last_i[grant];

  always_comb begin
    for (int i = 0; i < NUM_MST_PORTS; i++) begin
      m_r_ready_o[i] = s_r_ready_i && s_r_valid_o && (grant == select_t'(i));
    end
  end

  assign last_xfer = s_r_valid_o && s_r_ready_i && s_r_last_o;
  assign pop_o     = last_xfer;
  assign pop_id_o  = look_id_t'(s_r_id_o);

  // --------------------
  // Burst lock and pointer
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      if (!lock_q) begin
        lock_idx_q <= pick;
      end
      if (last_xfer) begin
        lock_q <= 1'b0;
        rr_q   <= (int'(grant) == NUM_MST_PORTS - 1) ? '0 : grant + select_t'(1);
      end else if (s_r_valid_o) begin
        lock_q <= 1'b1;
      end
    end
  end

  // A pending beat stays on the subordinate side until accepted
  a_grant_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (s_r_valid_o && !s_r_ready_i) |=>
      (s_r_valid_o && $stable(s_r_id_o) && $stable(s_r_data_o) &&
       $stable(s_r_resp_o) && $stable(s_r_last_o)))
    else $error("R grant moved while a beat was pending");

endmodule

// ==== rtl/axi_read_demux.sv ====
/*
 * AXI4 read demultiplexer
 * One subordinate read port to NUM_MST_PORTS manager read ports
 */
`timescale 1ns/1ns
module axi_read_demux #(
  parameter int NUM_MST_PORTS = demux_pkg::NUM_MST_PORTS,
  parameter int LOOK_BITS     = demux_pkg::LOOK_BITS,
  parameter int MAX_TRANS     = demux_pkg::MAX_TRANS
) (
  input  logic                                                 clk_i,
  input  logic                                                 rst_i,
  // Subordinate side
  input  demux_pkg::id_t                                       s_ar_id_i,
  input  logic [demux_pkg::ADDR_WIDTH-1:0]                     s_ar_addr_i,
  input  logic [demux_pkg::LEN_WIDTH-1:0]                      s_ar_len_i,
  input  demux_pkg::select_t                                   s_ar_select_i,
  input  logic                                                 s_ar_valid_i,
  output logic                                                 s_ar_ready_o,
  output demux_pkg::id_t                                       s_r_id_o,
  output logic [demux_pkg::DATA_WIDTH-1:0]                     s_r_data_o,
  output logic [1:0]                                           s_r_resp_o,
  output logic                                                 s_r_last_o,
  output logic                                                 s_r_valid_o,
  input  logic                                                 s_r_ready_i,
  // Manager side
  output demux_pkg::id_t                                       m_ar_id_o,
  output logic [demux_pkg::ADDR_WIDTH-1:0]                     m_ar_addr_o,
  output logic [demux_pkg::LEN_WIDTH-1:0]                      m_ar_len_o,
  output logic [NUM_MST_PORTS-1:0]                             m_ar_valid_o,
  input  logic [NUM_MST_PORTS-1:0]                             m_ar_ready_i,
  input  demux_pkg::id_t [NUM_MST_PORTS-1:0]                   m_r_id_i,
  input  logic [NUM_MST_PORTS-1:0][demux_pkg::DATA_WIDTH-1:0]  m_r_data_i,
  input  logic [NUM_MST_PORTS-1:0][1:0]                        m_r_resp_i,
  input  logic [NUM_MST_PORTS-1:0]                             m_r_last_i,
  input  logic [NUM_MST_PORTS-1:0]                             m_r_valid_i,
  output logic [NUM_MST_PORTS-1:0]                             m_r_ready_o
);
  import demux_pkg::*;

  look_id_t lookup_id;
  logic     occupied;
  select_t  stored_select;
  logic     full;
  logic     push;
  look_id_t pop_id;
  logic     pop;

  ar_route_ctrl #(
    .NUM_MST_PORTS   (NUM_MST_PORTS)
  ) u_ar_route_ctrl (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .s_ar_id_i       (s_ar_id_i),
    .s_ar_addr_i     (s_ar_addr_i),
    .s_ar_len_i      (s_ar_len_i),
    .s_ar_select_i   (s_ar_select_i),
    .s_ar_valid_i    (s_ar_valid_i),
    .s_ar_ready_o    (s_ar_ready_o),
    .m_ar_id_o       (m_ar_id_o),
    .m_ar_addr_o     (m_ar_addr_o),
    .m_ar_len_o      (m_ar_len_o),
    .m_ar_valid_o    (m_ar_valid_o),
    .m_ar_ready_i    (m_ar_ready_i),
    .lookup_id_o     (lookup_id),
    .occupied_i      (occupied),
    .stored_select_i (stored_select),
    .full_i          (full),
    .push_o          (push)
  );

  // Push ID and select come straight from the AR being looked up
  id_tracker #(
    .LOOK_BITS       (LOOK_BITS),
    .MAX_TRANS       (MAX_TRANS)
  ) u_id_tracker (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .lookup_id_i     (lookup_id),
    .occupied_o      (occupied),
    .stored_select_o (stored_select),
    .full_o          (full),
    .push_i          (push),
    .push_select_i   (s_ar_select_i),
    .pop_id_i        (pop_id),
    .pop_i           (pop)
  );

  r_arbiter #(
    .NUM_MST_PORTS   (NUM_MST_PORTS)
  ) u_r_arbiter (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .m_r_id_i        (m_r_id_i),
    .m_r_data_i      (m_r_data_i),
    .m_r_resp_i      (m_r_resp_i),
    .m_r_last_i      (m_r_last_i),
    .m_r_valid_i     (m_r_valid_i),
    .m_r_ready_o     (m_r_ready_o),
    .s_r_id_o        (s_r_id_o),
    .s_r_data_o      (s_r_data_o),
    .s_r_resp_o      (s_r_resp_o),
    .s_r_last_o      (s_r_last_o),
    .s_r_valid_o     (s_r_valid_o),
    .s_r_ready_i     (s_r_ready_i),
    .pop_id_o        (pop_id),
    .pop_o           (pop)
  );

endmodule

// ==== sim/tb_axi_read_demux.sv ====
/*
 * Testbench for the AXI4 read demultiplexer
 * Manager-port models answer ARs with tagged bursts checked per ID
 */
`timescale 1ns/1ns
module tb_axi_read_demux;
  import demux_pkg::*;

  localparam int NUM_PORTS   = NUM_MST_PORTS;
  localparam int NUM_LOOK    = 2 ** LOOK_BITS;
  localparam int NUM_TESTS   = 4;
  localparam int CYCLE_LIMIT = 200 * NUM_TESTS;

  typedef struct packed {
    id_t                   id;
    logic [ADDR_WIDTH-1:0] addr;
    logic [LEN_WIDTH-1:0]  len;
  } ar_rec_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } beat_t;

  logic                                 clk;
  logic                                 rst;
  id_t                                  s_ar_id;
  logic [ADDR_WIDTH-1:0]                s_ar_addr;
  logic [LEN_WIDTH-1:0]                 s_ar_len;
  select_t                              s_ar_select;
  logic                                 s_ar_valid;
  logic                                 s_ar_ready;
  id_t                                  s_r_id;
  logic [DATA_WIDTH-1:0]                s_r_data;
  logic [1:0]                           s_r_resp;
  logic                                 s_r_last;
  logic                                 s_r_valid;
  logic                                 s_r_ready;
  id_t                                  m_ar_id;
  logic [ADDR_WIDTH-1:0]                m_ar_addr;
  logic [LEN_WIDTH-1:0]                 m_ar_len;
  logic [NUM_PORTS-1:0]                 m_ar_valid;
  logic [NUM_PORTS-1:0]                 m_ar_ready;
  id_t [NUM_PORTS-1:0]                  m_r_id;
  logic [NUM_PORTS-1:0][DATA_WIDTH-1:0] m_r_data;
  logic [NUM_PORTS-1:0][1:0]            m_r_resp;
  logic [NUM_PORTS-1:0]                 m_r_last;
  logic [NUM_PORTS-1:0]                 m_r_valid;
  logic [NUM_PORTS-1:0]                 m_r_ready;

  // Port models and reference state
  ar_rec_t              port_q [NUM_PORTS][$];
  beat_t                exp_q [2**ID_WIDTH][$];
  logic [NUM_PORTS-1:0] busy;
  logic [NUM_PORTS-1:0] r_hold;
  logic [NUM_PORTS-1:0] ar_block;
  int unsigned          beat_idx [NUM_PORTS];
  int unsigned          dly [NUM_PORTS];
  int unsigned          tb_cnt [NUM_LOOK];
  select_t              tb_sel [NUM_LOOK];
  int unsigned          outstanding = 0;
  int unsigned          err_cnt = 0;
  int unsigned          check_cnt = 0;
  int unsigned          test_cnt = 0;
  int unsigned          cycle_cnt = 0;
  logic                 ar_seen;
  logic                 in_burst;
  id_t                  burst_id;
  logic [7:0]           burst_port;
  logic [31:0]          seed;

  axi_read_demux #(
    .NUM_MST_PORTS (NUM_MST_PORTS),
    .LOOK_BITS     (LOOK_BITS),
    .MAX_TRANS     (MAX_TRANS)
  ) dut (
    .clk_i (clk), .rst_i (rst),
    .s_ar_id_i (s_ar_id), .s_ar_addr_i (s_ar_addr), .s_ar_len_i (s_ar_len),
    .s_ar_select_i (s_ar_select), .s_ar_valid_i (s_ar_valid), .s_ar_ready_o (s_ar_ready),
    .s_r_id_o (s_r_id), .s_r_data_o (s_r_data), .s_r_resp_o (s_r_resp),
    .s_r_last_o (s_r_last), .s_r_valid_o (s_r_valid), .s_r_ready_i (s_r_ready),
    .m_ar_id_o (m_ar_id), .m_ar_addr_o (m_ar_addr), .m_ar_len_o (m_ar_len),
    .m_ar_valid_o (m_ar_valid), .m_ar_ready_i (m_ar_ready),
    .m_r_id_i (m_r_id), .m_r_data_i (m_r_data), .m_r_resp_i (m_r_resp),
    .m_r_last_i (m_r_last), .m_r_valid_i (m_r_valid), .m_r_ready_o (m_r_ready)
  );

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return 32'(seed[31:16]);
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    err_cnt++;
    $display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, want, $time);
  endtask

  task automatic report_error(input string what);
    err_cnt++;
    $display("Error at %0t: %s", $time, what);
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAIL");
      $finish;
    end
  end

  // --------------------
  // Checks on accepted transfers
  task automatic log_ar();
    look_id_t l;
    l = look_id_t'(s_ar_id);
    check_cnt++;
    a_route: assert (m_ar_valid == (NUM_PORTS'(1) << s_ar_select))
      else report_mismatch("m_ar_valid_o", 32'(m_ar_valid), 32'(NUM_PORTS'(1) << s_ar_select));
    a_route_id: assert (m_ar_id == s_ar_id)
      else report_mismatch("m_ar_id_o", 32'(m_ar_id), 32'(s_ar_id));
    a_route_addr: assert (m_ar_addr == s_ar_addr)
      else report_mismatch("m_ar_addr_o", m_ar_addr, s_ar_addr);
    a_route_len: assert (m_ar_len == s_ar_len)
      else report_mismatch("m_ar_len_o", 32'(m_ar_len), 32'(s_ar_len));
    a_order: assert (tb_cnt[l] == 0 || tb_sel[l] == s_ar_select)
      else report_error("AR accepted while its ID was outstanding on another port");
    tb_cnt[l]++;
    tb_sel[l] = s_ar_select;
    outstanding++;
    port_q[s_ar_select].push_back({s_ar_id, s_ar_addr, s_ar_len});
    // Port number in the top byte and address plus beat below
    // Response code is port plus beat index
    for (int i = 0; i <= int'(s_ar_len); i++) begin
      exp_q[s_ar_id].push_back({8'(s_ar_select), 24'(s_ar_addr + i),
                                2'(int'(s_ar_select) + i), i == int'(s_ar_len)});
    end
    ar_seen = 1'b1;
  endtask

  task automatic check_r_beat();
    beat_t    want;
    look_id_t l;
    l = look_id_t'(s_r_id);
    check_cnt++;
    if (in_burst) begin
      a_burst_id: assert (s_r_id == burst_id)
        else report_mismatch("s_r_id_o", 32'(s_r_id), 32'(burst_id));
      a_burst_port: assert (s_r_data[31:24] == burst_port)
        else report_mismatch("s_r_data_o port", 32'(s_r_data[31:24]), 32'(burst_port));
    end
    in_burst   = !s_r_last;
    burst_id   = s_r_id;
    burst_port = s_r_data[31:24];
    a_r_expected: assert (exp_q[s_r_id].size() != 0)
      else report_error("R beat arrived for an ID with no read outstanding");
    if (exp_q[s_r_id].size() != 0) begin
      want = exp_q[s_r_id].pop_front();
      a_r_data: assert (s_r_data == want.data)
        else report_mismatch("s_r_data_o", s_r_data, want.data);
      a_r_resp: assert (s_r_resp == want.resp)
        else report_mismatch("s_r_resp_o", 32'(s_r_resp), 32'(want.resp));
      a_r_last: assert (s_r_last == want.last)
        else report_mismatch("s_r_last_o", 32'(s_r_last), 32'(want.last));
    end
    if (s_r_last && tb_cnt[l] != 0) begin
      tb_cnt[l]--;
      outstanding--;
    end
  endtask

  // Burst progress and start delay per port
  task automatic advance_ports();
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (busy[p] && m_r_valid[p] && m_r_ready[p]) begin
        if (m_r_last[p]) begin
          busy[p] = 1'b0;
          void'(port_q[p].pop_front());
          dly[p] = next_rand() % 4;
        end else begin
          beat_idx[p]++;
        end
      end else if (!busy[p] && port_q[p].size() != 0 && !r_hold[p]) begin
        if (dly[p] == 0) begin
          busy[p]     = 1'b1;
          beat_idx[p] = 0;
        end else begin
          dly[p]--;
        end
      end
    end
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      for (int l = 0; l < NUM_LOOK; l++) begin
        if (tb_cnt[l] == MAX_TRANS) begin
          check_cnt++;
          a_full_stall: assert (!s_ar_ready)
            else report_error("AR accepted while an ID entry was full");
        end
      end
      if (s_ar_valid && s_ar_ready) begin
        log_ar();
      end
      if (s_r_valid && s_r_ready) begin
        check_r_beat();
      end
      advance_ports();
    end
  end

  a_ar_valid_stable: assert property (@(posedge clk) disable iff (rst)
    (|m_ar_valid && !(|(m_ar_valid & m_ar_ready))) |=>
      ($stable(m_ar_valid) && $stable(m_ar_id) && $stable(m_ar_addr) && $stable(m_ar_len)))
    else report_error("AR valid or payload changed before acceptance");

  // --------------------
  // Manager ports and R ready driven on the falling edge
  always @(negedge clk) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      m_ar_ready[p] = !ar_block[p] && ((next_rand() % 4) != 0);
      m_r_valid[p]  = busy[p];
      if (busy[p]) begin
        m_r_id[p]   = port_q[p][0].id;
        m_r_data[p] = {8'(p), 24'(port_q[p][0].addr + beat_idx[p])};
        m_r_resp[p] = 2'(p + beat_idx[p]);
        m_r_last[p] = (beat_idx[p] == 32'(port_q[p][0].len));
      end
    end
    s_r_ready = (next_rand() % 4) != 0;
  end

  // --------------------
  // Test sequences start on a falling edge
  task automatic send_ar(input id_t id, input select_t sel, input logic [7:0] len);
    ar_seen     = 1'b0;
    s_ar_id     = id;
    s_ar_addr   = next_rand() << 4;
    s_ar_len    = len;
    s_ar_select = sel;
    s_ar_valid  = 1'b1;
    while (!ar_seen) @(negedge clk);
    s_ar_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (outstanding != 0) @(negedge clk);
  endtask

  task automatic end_test(input string name, input int unsigned err_start);
    test_cnt++;
    if (err_cnt == err_start) begin
      $display("Test %-8s passed", name);
    end else begin
      $display("Test %-8s failed with %0d errors", name, err_cnt - err_start);
    end
  endtask

  task automatic run_random_test();
    int unsigned start;
    start = err_cnt;
    for (int n = 0; n < 20; n++) begin
      send_ar(id_t'(next_rand()), select_t'(next_rand()), 8'(next_rand() % 4));
    end
    wait_drained();
    end_test("random", start);
  endtask

  // Same ID on the same port passes and on another port it waits
  task automatic run_order_test();
    int unsigned start;
    start     = err_cnt;
    r_hold[0] = 1'b1;
    send_ar(4'h2, 2'd0, 8'd3);
    send_ar(4'h2, 2'd0, 8'd1);
    fork
      send_ar(4'h6, 2'd1, 8'd2);
      begin
        repeat (10) @(negedge clk);
        r_hold[0] = 1'b0;
      end
    join
    wait_drained();
    end_test("order", start);
  endtask

  task automatic run_full_test();
    int unsigned start;
    start     = err_cnt;
    r_hold[3] = 1'b1;
    for (int n = 0; n < MAX_TRANS; n++) begin
      send_ar(4'h1, 2'd3, 8'd0);
    end
    fork
      send_ar(4'h3, 2'd2, 8'd1);
      begin
        repeat (10) @(negedge clk);
        r_hold[3] = 1'b0;
      end
    join
    wait_drained();
    end_test("full", start);
  endtask

  // Locked AR survives the entry it was checked against draining away
  task automatic run_lock_test();
    int unsigned start;
    start     = err_cnt;
    r_hold[0] = 1'b1;
    send_ar(4'h1, 2'd0, 8'd1);
    ar_block[0] = 1'b1;
    @(negedge clk);
    fork
      send_ar(4'h5, 2'd0, 8'd0);
      begin
        repeat (3) @(negedge clk);
        r_hold[0] = 1'b0;
        while (tb_cnt[1] != 0) @(negedge clk);
        repeat (3) @(negedge clk);
        ar_block[0] = 1'b0;
      end
    join
    wait_drained();
    end_test("lock", start);
  endtask

  initial begin
    seed        = 32'h052d_91c1;
    rst         = 1'b1;
    s_ar_id     = '0;
    s_ar_addr   = '0;
    s_ar_len    = '0;
    s_ar_select = '0;
    s_ar_valid  = 1'b0;
    s_r_ready   = 1'b0;
    m_ar_ready  = '0;
    m_r_id      = '0;
    m_r_data    = '0;
    m_r_resp    = '0;
    m_r_last    = '0;
    m_r_valid   = '0;
    busy        = '0;
    r_hold      = '0;
    ar_block    = '0;
    ar_seen     = 1'b0;
    in_burst    = 1'b0;
    burst_id    = '0;
    burst_port  = '0;
    foreach (beat_idx[p]) begin
      beat_idx[p] = 0;
      dly[p]      = 0;
    end
    foreach (tb_cnt[l]) begin
      tb_cnt[l] = 0;
      tb_sel[l] = '0;
    end
    repeat (5) @(negedge clk);
    rst = 1'b0;
    run_random_test();
    run_order_test();
    run_full_test();
    run_lock_test();
    $display("Tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== files.f ====
rtl/demux_pkg.sv
rtl/ar_route_ctrl.sv
rtl/id_tracker.sv
rtl/r_arbiter.sv
rtl/axi_read_demux.sv
sim/tb_axi_read_demux.sv

// ==== Makefile ====
# Verilator simulation of the AXI4 read demultiplexer

VERILATOR ?= verilator
TOP       ?= tb_axi_read_demux
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

# Pass only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
